/* common/cpuDefs.sv */
package cpuDefs;

	// Instruction word
	localparam int INSTR_W = 16;
	typedef logic [INSTR_W-1:0] instrWord;

	// Field widths
	localparam int GROUP_W  = 4;
	localparam int FLAGS_W  = 2;
	localparam int MODE_W   = 2;
	localparam int REGA_W   = 3;
	localparam int ARG_W    = 4;
	localparam int OFFSET_W = FLAGS_W + ARG_W;

	typedef logic [GROUP_W-1:0]  groupT;
	typedef logic [FLAGS_W-1:0]  flagT;
	typedef logic [MODE_W-1:0]   modeT;
	typedef logic [REGA_W-1:0]   regFieldT;
	typedef logic [ARG_W-1:0]    argT;
	// Six-bit offset is {flags, arg}
	typedef logic [OFFSET_W-1:0] offsetT;

	// Field positions inside the instruction word
	localparam int GROUP_MSB = 15;
	localparam int GROUP_LSB = 12;
	localparam int FLAGS_MSB = 11;
	localparam int FLAGS_LSB = 10;
	localparam int LDS_BIT   = 9;
	localparam int MODE_MSB  = 8;
	localparam int MODE_LSB  = 7;
	localparam int REGA_MSB  = 6;
	localparam int REGA_LSB  = 4;
	localparam int ARG_MSB   = 3;
	localparam int ARG_LSB   = 0;

	// Group code of the load/store slice
	localparam groupT GROUP_LOAD_STORE = 4'h5;

	// Load or store select
	localparam logic LDS_LD = 1'b0;
	localparam logic LDS_ST = 1'b1;

	// Pointer adjust flags, register-indirect mode only
	localparam flagT LDSF_NONE     = 2'b00;
	localparam flagT LDSF_PRE_DEC  = 2'b01;
	localparam flagT LDSF_POST_INC = 2'b10;

	// Addressing modes
	localparam modeT MODE_REG_MEM      = 2'b00;
	localparam modeT MODE_REG_FRAME    = 2'b01;
	localparam modeT MODE_REG_STACK    = 2'b10;
	localparam modeT MODE_REG_RETSTACK = 2'b11;

	// Sequencer phases
	typedef enum logic [1:0] {
		FETCH,
		DECODE,
		EXECUTE,
		COMMIT
	} phaseT;

	// ALU operation
	typedef logic [3:0] aluOpT;
	localparam aluOpT ALU_OPX_NOP = 4'h0;
	localparam aluOpT ALU_OPX_MOV = 4'h1;
	localparam aluOpT ALU_OPX_ADD = 4'h2;
	localparam aluOpT ALU_OPX_SUB = 4'h3;

	// ALU A source and constant
	typedef logic [1:0] aluASrcT;
	localparam aluASrcT ALUA_SRCX_REG_A       = 2'h0;
	localparam aluASrcT ALUA_SRCX_INCREMENTER = 2'h1;

	typedef logic [1:0] aluAConstT;
	localparam aluAConstT ALUA_CONSTX_ZERO      = 2'h0;
	localparam aluAConstT ALUA_CONSTX_TWO       = 2'h1;
	localparam aluAConstT ALUA_CONSTX_MINUS_TWO = 2'h2;

	// ALU B source
	typedef logic [2:0] aluBSrcT;
	localparam aluBSrcT ALUB_SRCX_REG_B    = 3'h0;
	localparam aluBSrcT ALUB_SRCX_ARG_U6_0 = 3'h1;

	// Register file port A data and address
	typedef logic [1:0] regADinT;
	localparam regADinT REGA_DINX_NONE    = 2'h0;
	localparam regADinT REGA_DINX_ALUA_PP = 2'h1;

	typedef logic [2:0] regAAddrT;
	localparam regAAddrT REGA_ADDRX_ARGA = 3'h0;
	localparam regAAddrT REGA_ADDRX_RFP  = 3'h1;
	localparam regAAddrT REGA_ADDRX_RSP  = 3'h2;
	localparam regAAddrT REGA_ADDRX_RRS  = 3'h3;

	// Register file port B address
	typedef logic [1:0] regBAddrT;
	localparam regBAddrT REGB_ADDRX_ARGB = 2'h0;

	// Bus sources
	typedef logic [1:0] dataBusT;
	localparam dataBusT DATA_BUSX_NONE  = 2'h0;
	localparam dataBusT DATA_BUSX_REG_A = 2'h1;

	typedef logic [1:0] addrBusT;
	localparam addrBusT ADDR_BUSX_PC       = 2'h0;
	localparam addrBusT ADDR_BUSX_ALUA_DIN = 2'h1;
	localparam addrBusT ADDR_BUSX_ALU_R    = 2'h2;

endpackage

/* logic/instructionPhaseDecoder.sv */
`timescale 1ns/100ps

module instructionPhaseDecoder
	import cpuDefs::*;
(
	input  logic CLK,
	input  logic rst,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit
);

	phaseT phase;
	// Low until the first edge after reset
	logic running;

	// Parked on COMMIT so the first step lands on FETCH
	always_ff @(posedge CLK) begin
		if (rst) begin
			phase   <= COMMIT;
			running <= 1'b0;
		end else begin
			running <= 1'b1;
			case (phase)
				FETCH:   phase <= DECODE;
				DECODE:  phase <= EXECUTE;
				EXECUTE: phase <= COMMIT;
				default: phase <= FETCH;
			endcase
		end
	end

	assign fetch   = running && (phase == FETCH);
	assign decode  = running && (phase == DECODE);
	assign execute = running && (phase == EXECUTE);
	assign commit  = running && (phase == COMMIT);

	// One phase level at a time once out of reset
	phaseOneHot: assert property (
		@(posedge CLK) disable iff (rst)
		!$past(rst) |-> $onehot({fetch, decode, execute, commit})
	) else $error("phase levels not one-hot");

endmodule

/* decoder/loadStoreGroupDecoder.sv */
`timescale 1ns/100ps

module loadStoreGroupDecoder
	import cpuDefs::*;
(
	input  logic      CLK,
	input  logic      rst,
	input  instrWord  instr,
	input  logic      fetch,
	input  logic      execute,
	input  logic      commit,
	output groupT     group,
	output logic      regAEn,
	output logic      regBEn,
	output logic      regAWen,
	output logic      regBWen,
	output aluOpT     aluOp,
	output logic      aluLd,
	output aluAConstT aluAConst,
	output aluASrcT   aluASrc,
	output aluBSrcT   aluBSrc,
	output regADinT   regADin,
	output regAAddrT  regAAddr,
	output regBAddrT  regBAddr,
	output dataBusT   dataBus,
	output logic      dataBusOen,
	output addrBusT   addrBus
);

	instrWord  instrReg;
	flagT      flags;
	modeT      mode;
	logic      store;
	logic      regMem;
	// Register-indirect with a pointer adjust
	logic      adjust;
	aluASrcT   ptrSrc;
	aluAConstT ptrConst;

	// Word captured on the edge that closes FETCH
	always_ff @(posedge CLK) begin
		if (rst) begin
			instrReg <= '0;
		end else if (fetch) begin
			instrReg <= instr;
		end
	end

	assign group  = instrReg[GROUP_MSB:GROUP_LSB];
	assign flags  = instrReg[FLAGS_MSB:FLAGS_LSB];
	assign mode   = instrReg[MODE_MSB:MODE_LSB];
	assign store  = (instrReg[LDS_BIT] == LDS_ST);
	assign regMem = (mode == MODE_REG_MEM);
	assign adjust = regMem && ((flags == LDSF_PRE_DEC) || (flags == LDSF_POST_INC));

	// Pre-decrement addresses through the incrementer, else the raw pointer
	always_comb begin
		if (flags == LDSF_PRE_DEC) begin
			ptrSrc   = ALUA_SRCX_INCREMENTER;
			ptrConst = ALUA_CONSTX_MINUS_TWO;
		end else begin
			ptrSrc   = ALUA_SRCX_REG_A;
			ptrConst = ALUA_CONSTX_TWO;
		end
	end

	always_comb begin
		regAEn     = 1'b0;
		regBEn     = 1'b0;
		regAWen    = 1'b0;
		regBWen    = 1'b0;
		aluOp      = ALU_OPX_NOP;
		aluLd      = 1'b0;
		aluAConst  = ALUA_CONSTX_ZERO;
		aluASrc    = ALUA_SRCX_REG_A;
		aluBSrc    = ALUB_SRCX_REG_B;
		regADin    = REGA_DINX_NONE;
		regAAddr   = REGA_ADDRX_ARGA;
		regBAddr   = REGB_ADDRX_ARGB;
		dataBus    = DATA_BUSX_NONE;
		dataBusOen = 1'b0;
		addrBus    = ADDR_BUSX_PC;

		if (execute) begin
			regAEn     = 1'b1;
			regBEn     = store;
			regADin    = REGA_DINX_ALUA_PP;
			dataBusOen = store;
			if (store) begin
				dataBus = DATA_BUSX_REG_A;
			end

			if (regMem) begin
				aluOp     = ALU_OPX_MOV;
				aluASrc   = ptrSrc;
				aluAConst = ptrConst;
				aluBSrc   = ALUB_SRCX_REG_B;
				addrBus   = ADDR_BUSX_ALUA_DIN;
			end else begin
				// Pointer plus or minus the six-bit offset
				aluASrc   = ALUA_SRCX_REG_A;
				aluAConst = ALUA_CONSTX_TWO;
				aluBSrc   = ALUB_SRCX_ARG_U6_0;
				addrBus   = ADDR_BUSX_ALU_R;
				aluLd     = 1'b1;
				aluOp     = (mode == MODE_REG_FRAME) ? ALU_OPX_SUB : ALU_OPX_ADD;
				case (mode)
					MODE_REG_FRAME: regAAddr = REGA_ADDRX_RFP;
					MODE_REG_STACK: regAAddr = REGA_ADDRX_RSP;
					default:        regAAddr = REGA_ADDRX_RRS;
				endcase
			end
		end else if (commit) begin
			// Load data lands in register B
			regBEn  = !store;
			regBWen = !store;
			regAEn  = adjust;
			regAWen = adjust;
			// Adjusted pointer written back through the incrementer
			if (adjust) begin
				regADin   = REGA_DINX_ALUA_PP;
				aluASrc   = ptrSrc;
				aluAConst = ptrConst;
			end
		end
	end

	regAWenNeedsEn: assert property (
		@(posedge CLK) disable iff (rst)
		$rose(regAWen) |-> regAEn
	) else $error("regAWen rose without regAEn");

endmodule

/* decoder/controlMultiplexer.sv */
`timescale 1ns/100ps

module controlMultiplexer
	import cpuDefs::*;
(
	input  groupT     group,
	input  logic      lsRegAEn,
	input  logic      lsRegBEn,
	input  logic      lsRegAWen,
	input  logic      lsRegBWen,
	input  aluOpT     lsAluOp,
	input  logic      lsAluLd,
	input  aluAConstT lsAluAConst,
	input  aluASrcT   lsAluASrc,
	input  aluBSrcT   lsAluBSrc,
	input  regADinT   lsRegADin,
	input  regAAddrT  lsRegAAddr,
	input  regBAddrT  lsRegBAddr,
	input  dataBusT   lsDataBus,
	input  logic      lsDataBusOen,
	input  addrBusT   lsAddrBus,
	output logic      regAEn,
	output logic      regBEn,
	output logic      regAWen,
	output logic      regBWen,
	output aluOpT     aluOp,
	output logic      aluLd,
	output aluAConstT aluAConst,
	output aluASrcT   aluASrc,
	output aluBSrcT   aluBSrc,
	output regADinT   regADin,
	output regAAddrT  regAAddr,
	output regBAddrT  regBAddr,
	output dataBusT   dataBus,
	output logic      dataBusOen,
	output addrBusT   addrBus
);

	always_comb begin
		if (group == GROUP_LOAD_STORE) begin
			regAEn     = lsRegAEn;
			regBEn     = lsRegBEn;
			regAWen    = lsRegAWen;
			regBWen    = lsRegBWen;
			aluOp      = lsAluOp;
			aluLd      = lsAluLd;
			aluAConst  = lsAluAConst;
			aluASrc    = lsAluASrc;
			aluBSrc    = lsAluBSrc;
			regADin    = lsRegADin;
			regAAddr   = lsRegAAddr;
			regBAddr   = lsRegBAddr;
			dataBus    = lsDataBus;
			dataBusOen = lsDataBusOen;
			addrBus    = lsAddrBus;
		end else begin
			// Other groups leave the register file and buses alone
			regAEn     = 1'b0;
			regBEn     = 1'b0;
			regAWen    = 1'b0;
			regBWen    = 1'b0;
			aluOp      = ALU_OPX_NOP;
			aluLd      = 1'b0;
			aluAConst  = ALUA_CONSTX_ZERO;
			aluASrc    = ALUA_SRCX_REG_A;
			aluBSrc    = ALUB_SRCX_REG_B;
			regADin    = REGA_DINX_NONE;
			regAAddr   = REGA_ADDRX_ARGA;
			regBAddr   = REGB_ADDRX_ARGB;
			dataBus    = DATA_BUSX_NONE;
			dataBusOen = 1'b0;
			addrBus    = ADDR_BUSX_PC;
		end
	end

	// Store drives the bus in execute, load writes B in commit
	always_comb begin
		busVsWrite: assert final (!(dataBusOen && regBWen))
			else $error("dataBusOen high with regBWen");
	end

endmodule

/* logic/loadStoreControlUnit.sv */
`timescale 1ns/100ps

module loadStoreControlUnit
	import cpuDefs::*;
(
	input  logic      CLK,
	input  logic      rst,
	input  instrWord  instr,
	output logic      fetch,
	output logic      decode,
	output logic      execute,
	output logic      commit,
	output logic      regAEn,
	output logic      regBEn,
	output logic      regAWen,
	output logic      regBWen,
	output aluOpT     aluOp,
	output logic      aluLd,
	output aluAConstT aluAConst,
	output aluASrcT   aluASrc,
	output aluBSrcT   aluBSrc,
	output regADinT   regADin,
	output regAAddrT  regAAddr,
	output regBAddrT  regBAddr,
	output dataBusT   dataBus,
	output logic      dataBusOen,
	output addrBusT   addrBus
);

	// Raw decoder controls ahead of the group select
	groupT     group;
	logic      lsRegAEn;
	logic      lsRegBEn;
	logic      lsRegAWen;
	logic      lsRegBWen;
	aluOpT     lsAluOp;
	logic      lsAluLd;
	aluAConstT lsAluAConst;
	aluASrcT   lsAluASrc;
	aluBSrcT   lsAluBSrc;
	regADinT   lsRegADin;
	regAAddrT  lsRegAAddr;
	regBAddrT  lsRegBAddr;
	dataBusT   lsDataBus;
	logic      lsDataBusOen;
	addrBusT   lsAddrBus;

	instructionPhaseDecoder u_instructionPhaseDecoder (
		.CLK(CLK), .rst(rst),
		.fetch(fetch), .decode(decode), .execute(execute), .commit(commit)
	);

	loadStoreGroupDecoder u_loadStoreGroupDecoder (
		.CLK(CLK), .rst(rst), .instr(instr),
		.fetch(fetch), .execute(execute), .commit(commit),
		.group(group),
		.regAEn(lsRegAEn), .regBEn(lsRegBEn), .regAWen(lsRegAWen), .regBWen(lsRegBWen),
		.aluOp(lsAluOp), .aluLd(lsAluLd), .aluAConst(lsAluAConst),
		.aluASrc(lsAluASrc), .aluBSrc(lsAluBSrc),
		.regADin(lsRegADin), .regAAddr(lsRegAAddr), .regBAddr(lsRegBAddr),
		.dataBus(lsDataBus), .dataBusOen(lsDataBusOen), .addrBus(lsAddrBus)
	);

	controlMultiplexer u_controlMultiplexer (
		.group(group),
		.lsRegAEn(lsRegAEn), .lsRegBEn(lsRegBEn),
		.lsRegAWen(lsRegAWen), .lsRegBWen(lsRegBWen),
		.lsAluOp(lsAluOp), .lsAluLd(lsAluLd), .lsAluAConst(lsAluAConst),
		.lsAluASrc(lsAluASrc), .lsAluBSrc(lsAluBSrc),
		.lsRegADin(lsRegADin), .lsRegAAddr(lsRegAAddr), .lsRegBAddr(lsRegBAddr),
		.lsDataBus(lsDataBus), .lsDataBusOen(lsDataBusOen), .lsAddrBus(lsAddrBus),
		.regAEn(regAEn), .regBEn(regBEn), .regAWen(regAWen), .regBWen(regBWen),
		.aluOp(aluOp), .aluLd(aluLd), .aluAConst(aluAConst),
		.aluASrc(aluASrc), .aluBSrc(aluBSrc),
		.regADin(regADin), .regAAddr(regAAddr), .regBAddr(regBAddr),
		.dataBus(dataBus), .dataBusOen(dataBusOen), .addrBus(addrBus)
	);

endmodule

/* tests/clockGen.sv */
`timescale 1ns/100ps

module clockGen (
	output logic CLK,
	output logic rst
);

	localparam time HALF_PERIOD = 20ns;
	localparam time DRIVE_DELAY = 1ns;

	initial begin
		CLK = 1'b0;
		forever #(HALF_PERIOD) CLK = ~CLK;
	end

	// Reset covers the first two rising edges
	initial begin
		rst = 1'b1;
		repeat (2) @(posedge CLK);
		#(DRIVE_DELAY);
		rst = 1'b0;
	end

endmodule

/* tests/loadStoreControlUnitTb.sv */
`timescale 1ns/100ps

module loadStoreControlUnitTb
	import cpuDefs::*;
;

	localparam int WAIT_LIMIT = 8;

	typedef struct packed {
		logic      regAEn;
		logic      regBEn;
		logic      regAWen;
		logic      regBWen;
		aluOpT     aluOp;
		logic      aluLd;
		aluAConstT aluAConst;
		aluASrcT   aluASrc;
		aluBSrcT   aluBSrc;
		regADinT   regADin;
		regAAddrT  regAAddr;
		regBAddrT  regBAddr;
		dataBusT   dataBus;
		logic      dataBusOen;
		addrBusT   addrBus;
	} ctlT;

	// Commit enables are {regAEn, regBEn, regAWen, regBWen}
	typedef struct packed {
		instrWord   instr;
		ctlT        exe;
		logic [3:0] cmt;
	} rowT;

	logic      CLK;
	logic      rst;
	instrWord  instr;
	logic      fetch, decode, execute, commit;
	logic      regAEn, regBEn, regAWen, regBWen;
	aluOpT     aluOp;
	logic      aluLd;
	aluAConstT aluAConst;
	aluASrcT   aluASrc;
	aluBSrcT   aluBSrc;
	regADinT   regADin;
	regAAddrT  regAAddr;
	regBAddrT  regBAddr;
	dataBusT   dataBus;
	logic      dataBusOen;
	addrBusT   addrBus;
	logic [3:0] phases;

	rowT rows[$];
	int  seed = 76738;
	int  errorCount = 0;
	int  timeoutCount = 0;
	int  rowIdx = -1;

	assign phases = {fetch, decode, execute, commit};

	clockGen u_clockGen (.CLK(CLK), .rst(rst));

	loadStoreControlUnit u_loadStoreControlUnit (.*);

	task automatic check(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (actual !== expected) begin
			$display("error: %s expected 0x%0h got 0x%0h (row %0d)",
				name, expected, actual, rowIdx);
			errorCount++;
		end
	endtask

	// Sel 0..3 picks fetch, decode, execute, commit
	task automatic waitPhase(input int sel, input string name, input int limit);
		int n;
		n = 0;
		while (phases[3-sel] !== 1'b1 && n < limit) begin
			@(posedge CLK);
			#5;
			n++;
		end
		if (phases[3-sel] !== 1'b1) begin
			$display("timeout: %s phase did not arrive within %0d cycles", name, limit);
			timeoutCount++;
		end
	endtask

	task automatic waitRstLow();
		int n;
		n = 0;
		while (rst !== 1'b0 && n < WAIT_LIMIT) begin
			@(posedge CLK);
			#5;
			n++;
		end
		if (rst !== 1'b0) begin
			$display("timeout: reset never released");
			timeoutCount++;
		end
	endtask

	task automatic checkExecute(input ctlT e);
		check("regAEn", 16'(e.regAEn), 16'(regAEn));
		check("regBEn", 16'(e.regBEn), 16'(regBEn));
		check("regAWen", 16'(e.regAWen), 16'(regAWen));
		check("regBWen", 16'(e.regBWen), 16'(regBWen));
		check("aluOp", 16'(e.aluOp), 16'(aluOp));
		check("aluLd", 16'(e.aluLd), 16'(aluLd));
		check("aluAConst", 16'(e.aluAConst), 16'(aluAConst));
		check("aluASrc", 16'(e.aluASrc), 16'(aluASrc));
		check("aluBSrc", 16'(e.aluBSrc), 16'(aluBSrc));
		check("regADin", 16'(e.regADin), 16'(regADin));
		check("regAAddr", 16'(e.regAAddr), 16'(regAAddr));
		check("regBAddr", 16'(e.regBAddr), 16'(regBAddr));
		check("dataBus", 16'(e.dataBus), 16'(dataBus));
		check("dataBusOen", 16'(e.dataBusOen), 16'(dataBusOen));
		check("addrBus", 16'(e.addrBus), 16'(addrBus));
	endtask

	task automatic checkCommit(input logic [3:0] en);
		check("regAEn", 16'(en[3]), 16'(regAEn));
		check("regBEn", 16'(en[2]), 16'(regBEn));
		check("regAWen", 16'(en[1]), 16'(regAWen));
		check("regBWen", 16'(en[0]), 16'(regBWen));
	endtask

	function automatic instrWord makeInstr(groupT g, flagT f, logic st, modeT m,
			regFieldT r, argT a);
		return {g, f, st, m, r, a};
	endfunction

	task automatic addRow(input instrWord w, input ctlT e, input logic [3:0] cmt);
		rowT row;
		row.instr = w;
		row.exe   = e;
		row.cmt   = cmt;
		rows.push_back(row);
	endtask

	task automatic buildRows();
		ctlT    idle, mem, ptr, e;
		int     r;
		offsetT off;
		// Every idle code is zero
		idle = '0;
		mem = idle;
		mem.regAEn    = 1'b1;
		mem.regADin   = REGA_DINX_ALUA_PP;
		mem.aluOp     = ALU_OPX_MOV;
		mem.aluAConst = ALUA_CONSTX_TWO;
		mem.addrBus   = ADDR_BUSX_ALUA_DIN;
		addRow(makeInstr(GROUP_LOAD_STORE, LDSF_NONE, LDS_LD, MODE_REG_MEM, 3'd3, 4'h1),
			mem, 4'b0101);
		e = mem;
		e.aluASrc   = ALUA_SRCX_INCREMENTER;
		e.aluAConst = ALUA_CONSTX_MINUS_TWO;
		addRow(makeInstr(GROUP_LOAD_STORE, LDSF_PRE_DEC, LDS_LD, MODE_REG_MEM, 3'd5, 4'h2),
			e, 4'b1111);
		addRow(makeInstr(GROUP_LOAD_STORE, LDSF_POST_INC, LDS_LD, MODE_REG_MEM, 3'd1, 4'h7),
			mem, 4'b1111);
		// Stores read B and drive the data bus
		e = mem;
		e.regBEn     = 1'b1;
		e.dataBus    = DATA_BUSX_REG_A;
		e.dataBusOen = 1'b1;
		addRow(makeInstr(GROUP_LOAD_STORE, LDSF_NONE, LDS_ST, MODE_REG_MEM, 3'd2, 4'h4),
			e, 4'b0000);
		addRow(makeInstr(GROUP_LOAD_STORE, LDSF_POST_INC, LDS_ST, MODE_REG_MEM, 3'd6, 4'h0),
			e, 4'b1010);
		ptr = idle;
		ptr.regAEn    = 1'b1;
		ptr.regADin   = REGA_DINX_ALUA_PP;
		ptr.aluAConst = ALUA_CONSTX_TWO;
		ptr.aluBSrc   = ALUB_SRCX_ARG_U6_0;
		ptr.addrBus   = ADDR_BUSX_ALU_R;
		ptr.aluLd     = 1'b1;
		for (int m = 1; m < 4; m++) begin
			r   = $random(seed);
			off = r[5:0];
			e = ptr;
			e.aluOp    = (m == 1) ? ALU_OPX_SUB : ALU_OPX_ADD;
			e.regAAddr = (m == 1) ? REGA_ADDRX_RFP : (m == 2) ? REGA_ADDRX_RSP : REGA_ADDRX_RRS;
			addRow(makeInstr(GROUP_LOAD_STORE, off[5:4], LDS_LD, modeT'(m), 3'd4, off[3:0]),
				e, 4'b0101);
		end
		// Foreign group must stay idle
		addRow(makeInstr(4'h3, LDSF_PRE_DEC, LDS_ST, MODE_REG_MEM, 3'd7, 4'hf), idle, 4'b0000);
	endtask

	initial begin
		instr = '0;
		buildRows();
		@(posedge CLK);
		#5;
		check("phases", 16'(4'b0000), 16'(phases));
		checkCommit(4'b0000);
		check("aluLd", 16'(1'b0), 16'(aluLd));
		check("dataBusOen", 16'(1'b0), 16'(dataBusOen));
		waitRstLow();
		if (timeoutCount == 0) begin
			waitPhase(0, "fetch", 1);
		end
		// Two full rounds of phase rotation
		if (timeoutCount == 0) begin
			for (int k = 0; k < 8; k++) begin
				check("phases", 16'(4'b1000 >> (k % 4)), 16'(phases));
				@(posedge CLK);
				#5;
			end
		end
		for (int i = 0; i < rows.size() && timeoutCount == 0; i++) begin
			rowIdx = i;
			waitPhase(0, "fetch", WAIT_LIMIT);
			if (timeoutCount != 0) break;
			instr = rows[i].instr;
			waitPhase(2, "execute", WAIT_LIMIT);
			if (timeoutCount != 0) break;
			checkExecute(rows[i].exe);
			waitPhase(3, "commit", WAIT_LIMIT);
			if (timeoutCount != 0) break;
			checkCommit(rows[i].cmt);
		end
		$display("errors: %0d  timeouts: %0d", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* project.f */
common/cpuDefs.sv
logic/instructionPhaseDecoder.sv
decoder/loadStoreGroupDecoder.sv
decoder/controlMultiplexer.sv
logic/loadStoreControlUnit.sv
tests/clockGen.sv
tests/loadStoreControlUnitTb.sv

/* run.sh */
#!/bin/sh
# Build and run the load/store control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f project.f \
	--top-module loadStoreControlUnitTb -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
	exit 1
fi
exit 0
